/* bench/engine_pipeline_tb.sv */
// ------------------------------------------------
// Directed testbench for the engine pipeline slot:
// reset, transfers, back-pressure and done tracking
// ------------------------------------------------
`include "engine_pipeline_settings.svh"
`default_nettype none
`timescale 1ns/1ps

module engine_pipeline_tb;

    import engine_pipeline_pkg::*;

    localparam int CLK_NS      = 40;
    localparam int STREAM_PKTS = 20;
    localparam int BP_MAX_PKTS = 40;
    localparam int DONE_PKTS   = 4;
    localparam int DRAIN_LIMIT = 300;
    // Single 2, streams 2x20, back-pressure up to 40, done 4
    localparam int TOTAL_PKTS  = 2 + 2 * STREAM_PKTS + BP_MAX_PKTS + DONE_PKTS;
    localparam int WATCHDOG_CYCLES = TOTAL_PKTS * 40 + 200;

    logic            ap_clk;
    logic            areset_template_engine;
    logic            response_engine_valid;
    memory_payload_t response_engine_payload;
    logic            response_engine_prog_full;
    logic            request_engine_pop;
    logic            request_engine_valid;
    memory_payload_t request_engine_payload;
    logic            response_memory_valid;
    memory_payload_t response_memory_payload;
    logic            response_memory_prog_full;
    logic            request_memory_pop;
    logic            request_memory_valid;
    memory_payload_t request_memory_payload;
    logic            fifo_setup;
    logic            done_out;

    memory_payload_t engine_expected [$];
    memory_payload_t memory_expected [$];
    logic [31:0]     lfsr_state = 32'hec4e175c;
    int              payload_checks = 0;
    int              payload_errors = 0;
    int              flag_checks = 0;
    int              flag_errors = 0;
    int              engine_received = 0;
    int              memory_received = 0;

    tb_clock_gen clock_inst (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine)
    );

    engine_pipeline engine_pipeline_inst (
        .ap_clk                   (ap_clk),
        .areset_template_engine   (areset_template_engine),
        .response_engine_valid    (response_engine_valid),
        .response_engine_payload  (response_engine_payload),
        .response_engine_prog_full(response_engine_prog_full),
        .request_engine_pop       (request_engine_pop),
        .request_engine_valid     (request_engine_valid),
        .request_engine_payload   (request_engine_payload),
        .response_memory_valid    (response_memory_valid),
        .response_memory_payload  (response_memory_payload),
        .response_memory_prog_full(response_memory_prog_full),
        .request_memory_pop       (request_memory_pop),
        .request_memory_valid     (request_memory_valid),
        .request_memory_payload   (request_memory_payload),
        .fifo_setup               (fifo_setup),
        .done_out                 (done_out)
    );

    // ------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic make_payload(output memory_payload_t p);
        logic [$bits(memory_payload_t)-1:0] bits;
        for (int i = 0; i < $bits(memory_payload_t); i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits[i] = lfsr_state[0];
        end
        p = bits;
    endtask

    task automatic check_payload(input string name, input memory_payload_t actual,
                                 input memory_payload_t expected);
        payload_checks++;
        if (actual !== expected) begin
            payload_errors++;
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        flag_checks++;
        if (actual !== expected) begin
            flag_errors++;
            $display("FAIL t=%0t %s: got %b expected %b", $time, name, actual, expected);
        end
    endtask

    // Decide at the falling edge, drive at the next rising edge
    task automatic send_streams(input int engine_count, input int memory_count);
        int              engine_left;
        int              memory_left;
        logic            send_engine;
        logic            send_memory;
        memory_payload_t p;
        engine_left = engine_count;
        memory_left = memory_count;
        while (engine_left > 0 || memory_left > 0) begin
            @(negedge ap_clk);
            send_engine = (engine_left > 0) && !response_engine_prog_full;
            send_memory = (memory_left > 0) && !response_memory_prog_full;
            @(posedge ap_clk);
            response_engine_valid <= send_engine;
            response_memory_valid <= send_memory;
            if (send_engine) begin
                make_payload(p);
                response_engine_payload <= p;
                engine_expected.push_back(p);
                engine_left--;
            end
            if (send_memory) begin
                make_payload(p);
                response_memory_payload <= p;
                memory_expected.push_back(p);
                memory_left--;
            end
        end
        @(posedge ap_clk);
        response_engine_valid <= 1'b0;
        response_memory_valid <= 1'b0;
    endtask

    task automatic wait_drain(input string what, output logic saw_done_low);
        int cycles;
        cycles = 0;
        saw_done_low = 1'b0;
        while ((engine_expected.size() != 0 || memory_expected.size() != 0)
               && cycles < DRAIN_LIMIT) begin
            @(negedge ap_clk);
            if (done_out === 1'b0) begin
                saw_done_low = 1'b1;
            end
            cycles++;
        end
        if (engine_expected.size() != 0 || memory_expected.size() != 0) begin
            flag_errors++;
            $display("ERROR t=%0t %s: %0d engine and %0d memory packets never arrived",
                     $time, what, engine_expected.size(), memory_expected.size());
            engine_expected.delete();
            memory_expected.delete();
        end
    endtask

    task automatic wait_done_high();
        int cycles;
        cycles = 0;
        while (done_out !== 1'b1 && cycles < 10) begin
            @(negedge ap_clk);
            cycles++;
        end
        check_flag("done_out", done_out, 1'b1);
    endtask

    // ------------------------------------------------
    // Directed tests
    // ------------------------------------------------
    task automatic reset_state_test();
        int cycles;
        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        check_flag("request_engine_valid", request_engine_valid, 1'b0);
        check_flag("request_memory_valid", request_memory_valid, 1'b0);
        check_flag("done_out", done_out, 1'b0);
        check_flag("fifo_setup", fifo_setup, 1'b1);
        wait (areset_template_engine === 1'b0);
        cycles = 0;
        while (fifo_setup === 1'b1 && cycles <= `ENGINE_RST_BUSY_CYCLES + 2) begin
            @(negedge ap_clk);
            cycles++;
        end
        if (fifo_setup !== 1'b0 || cycles > `ENGINE_RST_BUSY_CYCLES + 2) begin
            flag_errors++;
            $display("ERROR t=%0t fifo_setup did not fall in time after reset", $time);
        end
        wait_done_high();
    endtask

    task automatic transfer_test(input string what, input int count);
        logic saw_done_low;
        send_streams(count, count);
        wait_drain(what, saw_done_low);
        check_flag("done_out low in flight", saw_done_low, 1'b1);
    endtask

    task automatic back_pressure_test();
        int              sent;
        int              rx_start;
        logic            saw_done_low;
        memory_payload_t p;
        sent = 0;
        rx_start = engine_received;
        @(posedge ap_clk);
        request_engine_pop <= 1'b0;
        @(negedge ap_clk);
        while (!response_engine_prog_full && sent < BP_MAX_PKTS) begin
            @(posedge ap_clk);
            make_payload(p);
            response_engine_valid   <= 1'b1;
            response_engine_payload <= p;
            engine_expected.push_back(p);
            sent++;
            @(negedge ap_clk);
        end
        @(posedge ap_clk);
        response_engine_valid <= 1'b0;
        if (sent >= BP_MAX_PKTS) begin
            flag_errors++;
            $display("ERROR t=%0t response_engine_prog_full never rose", $time);
        end
        // Stalled: nothing may leave and the upstream flag must hold
        repeat (20) @(negedge ap_clk);
        check_flag("response_engine_prog_full", response_engine_prog_full, 1'b1);
        // Idle memory channel is not throttled by the engine stall
        check_flag("response_memory_prog_full", response_memory_prog_full, 1'b0);
        if (engine_received != rx_start) begin
            flag_errors++;
            $display("ERROR t=%0t engine packets left while pop was low", $time);
        end
        @(posedge ap_clk);
        request_engine_pop <= 1'b1;
        wait_drain("back-pressure", saw_done_low);
        check_flag("done_out low while stalled", saw_done_low, 1'b1);
        if (engine_received - rx_start != sent) begin
            flag_errors++;
            $display("ERROR t=%0t back-pressure sent %0d packets but %0d arrived",
                     $time, sent, engine_received - rx_start);
        end
    endtask

    task automatic done_tracking_test();
        logic saw_done_low;
        wait_done_high();
        send_streams(0, DONE_PKTS);
        wait_drain("done tracking", saw_done_low);
        check_flag("done_out low in flight", saw_done_low, 1'b1);
        wait_done_high();
    endtask

    // ------------------------------------------------
    // Output monitor
    // ------------------------------------------------
    always @(negedge ap_clk) begin
        if (areset_template_engine === 1'b0 && request_engine_valid === 1'b1) begin
            engine_received++;
            if (engine_expected.size() == 0) begin
                payload_errors++;
                $display("ERROR t=%0t packet on engine channel with none expected", $time);
            end else begin
                check_payload("request_engine_payload", request_engine_payload,
                              engine_expected.pop_front());
            end
        end
        if (areset_template_engine === 1'b0 && request_memory_valid === 1'b1) begin
            memory_received++;
            if (memory_expected.size() == 0) begin
                payload_errors++;
                $display("ERROR t=%0t packet on memory channel with none expected", $time);
            end else begin
                check_payload("request_memory_payload", request_memory_payload,
                              memory_expected.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("ERROR watchdog expired after %0d cycles, tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        response_engine_valid   <= 1'b0;
        response_engine_payload <= '0;
        request_engine_pop      <= 1'b1;
        response_memory_valid   <= 1'b0;
        response_memory_payload <= '0;
        request_memory_pop      <= 1'b1;
        reset_state_test();
        transfer_test("single transfer", 1);
        transfer_test("concurrent streams", STREAM_PKTS);
        back_pressure_test();
        done_tracking_test();
        $display("Checks %0d payload %0d flag, errors %0d payload %0d other, rx %0d/%0d",
                 payload_checks, flag_checks, payload_errors, flag_errors,
                 engine_received, memory_received);
        if (payload_errors == 0 && flag_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : engine_pipeline_tb

`default_nettype wire

/* bench/tb_clock_gen.sv */
// ------------------------------------------------
// Testbench clock, 40 ns period, with reset held
// high for the first 5 rising edges
// ------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic ap_clk,
    output logic areset_template_engine
);

    initial begin
        ap_clk = 1'b0;
        forever begin
            #20 ap_clk = ~ap_clk;
        end
    end

    initial begin
        areset_template_engine <= 1'b1;
        repeat (5) @(posedge ap_clk);
        areset_template_engine <= 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

/* engine_pipeline.f */
+incdir+verilog
verilog/engine_pipeline_pkg.sv
verilog/fifo_status_if.sv
verilog/packet_fifo.sv
verilog/response_ingress.sv
verilog/stage_pipeline.sv
verilog/request_egress.sv
verilog/engine_pipeline.sv
bench/tb_clock_gen.sv
bench/engine_pipeline_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the engine pipeline testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f engine_pipeline.f --top-module engine_pipeline_tb \
    -Mdir obj_dir -o engine_pipeline_sim || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/engine_pipeline_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "Finished with no errors" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* verilog/engine_pipeline.sv */
// ------------------------------------------------
// Engine slot top: engine and memory channels, each
// ingress queue, delay stages, egress queue
// ------------------------------------------------
`include "engine_pipeline_settings.svh"
`default_nettype none
`timescale 1ns/1ps

module engine_pipeline (
    input  logic                                 ap_clk,
    input  logic                                 areset_template_engine,
    // Engine channel
    input  logic                                 response_engine_valid,
    input  engine_pipeline_pkg::memory_payload_t response_engine_payload,
    output logic                                 response_engine_prog_full,
    input  logic                                 request_engine_pop,
    output logic                                 request_engine_valid,
    output engine_pipeline_pkg::memory_payload_t request_engine_payload,
    // Memory channel
    input  logic                                 response_memory_valid,
    input  engine_pipeline_pkg::memory_payload_t response_memory_payload,
    output logic                                 response_memory_prog_full,
    input  logic                                 request_memory_pop,
    output logic                                 request_memory_valid,
    output engine_pipeline_pkg::memory_payload_t request_memory_payload,
    // Slot status
    output logic                                 fifo_setup,
    output logic                                 done_out
);

    import engine_pipeline_pkg::*;

    fifo_status_if in_engine_status ();
    fifo_status_if in_memory_status ();
    fifo_status_if out_engine_status ();
    fifo_status_if out_memory_status ();

    memory_packet_t engine_ingress_pkt;
    memory_packet_t engine_delayed_pkt;
    memory_packet_t memory_ingress_pkt;
    memory_packet_t memory_delayed_pkt;
    logic           all_empty_q;

    // ------------------------------------------------
    // Engine channel
    // ------------------------------------------------
    response_ingress engine_ingress_inst (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .in_valid              (response_engine_valid),
        .in_payload            (response_engine_payload),
        .egress_status         (out_engine_status),
        .packet_out            (engine_ingress_pkt),
        .status                (in_engine_status)
    );

    stage_pipeline #(
        .STAGES(`ENGINE_PIPELINE_STAGES)
    ) engine_stages_inst (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .packet_in             (engine_ingress_pkt),
        .packet_out            (engine_delayed_pkt)
    );

    request_egress engine_egress_inst (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .packet_in             (engine_delayed_pkt),
        .pop                   (request_engine_pop),
        .out_valid             (request_engine_valid),
        .out_payload           (request_engine_payload),
        .status                (out_engine_status)
    );

    // ------------------------------------------------
    // Memory channel
    // ------------------------------------------------
    response_ingress memory_ingress_inst (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .in_valid              (response_memory_valid),
        .in_payload            (response_memory_payload),
        .egress_status         (out_memory_status),
        .packet_out            (memory_ingress_pkt),
        .status                (in_memory_status)
    );

    stage_pipeline #(
        .STAGES(`ENGINE_PIPELINE_STAGES)
    ) memory_stages_inst (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .packet_in             (memory_ingress_pkt),
        .packet_out            (memory_delayed_pkt)
    );

    request_egress memory_egress_inst (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .packet_in             (memory_delayed_pkt),
        .pop                   (request_memory_pop),
        .out_valid             (request_memory_valid),
        .out_payload           (request_memory_payload),
        .status                (out_memory_status)
    );

    // Upstream throttle per channel
    assign response_engine_prog_full = in_engine_status.prog_full;
    assign response_memory_prog_full = in_memory_status.prog_full;

    // ------------------------------------------------
    // Setup and done flags
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            fifo_setup  <= 1'b1;
            all_empty_q <= 1'b0;
            done_out    <= 1'b0;
        end else begin
            fifo_setup  <= in_engine_status.rst_busy | in_memory_status.rst_busy |
                           out_engine_status.rst_busy | out_memory_status.rst_busy;
            all_empty_q <= in_engine_status.empty & in_memory_status.empty &
                           out_engine_status.empty & out_memory_status.empty;
            // One extra cycle so the last output register has settled
            done_out    <= all_empty_q;
        end
    end

endmodule : engine_pipeline

`default_nettype wire

/* verilog/engine_pipeline_pkg.sv */
// ------------------------------------------------
// Packet types shared by all engine pipeline blocks;
// compile before any module that imports it
// ------------------------------------------------
`include "engine_pipeline_settings.svh"
`default_nettype none

package engine_pipeline_pkg;

    // ------------------------------------------------
    // Memory packet
    // ------------------------------------------------

    // Payload carried through the queues, 72 bits
    typedef struct packed {
        logic [`ENGINE_ID_WIDTH-1:0]   id;
        logic [`ENGINE_ADDR_WIDTH-1:0] address;
        logic [`ENGINE_DATA_WIDTH-1:0] data;
    } memory_payload_t;

    // Stage-to-stage form, valid high for one cycle per packet
    typedef struct packed {
        logic            valid;
        memory_payload_t payload;
    } memory_packet_t;

endpackage : engine_pipeline_pkg

`default_nettype wire

/* verilog/engine_pipeline_settings.svh */
// ------------------------------------------------
// Build-time settings for the engine pipeline slot:
// field widths, queue sizing and delay depth
// ------------------------------------------------
`ifndef ENGINE_PIPELINE_SETTINGS_SVH
`define ENGINE_PIPELINE_SETTINGS_SVH

// Packet field widths
`define ENGINE_ID_WIDTH        8
`define ENGINE_ADDR_WIDTH      32
`define ENGINE_DATA_WIDTH      32

// Queue sizing
`define ENGINE_FIFO_DEPTH      16
`define ENGINE_PROG_THRESH     8
`define ENGINE_RST_BUSY_CYCLES 2

// Delay registers between ingress and egress
`define ENGINE_PIPELINE_STAGES 2

`endif

/* verilog/fifo_status_if.sv */
// ------------------------------------------------
// Status flags of one queue; the owning block drives
// the source side, readers take the sink side
// ------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

interface fifo_status_if;

    logic empty;
    logic full;
    // Fill level at or above threshold
    logic prog_full;
    // High while the queue comes out of reset
    logic rst_busy;

    modport source (
        output empty,
        output full,
        output prog_full,
        output rst_busy
    );

    modport sink (
        input empty,
        input full,
        input prog_full,
        input rst_busy
    );

endinterface : fifo_status_if

`default_nettype wire

/* verilog/packet_fifo.sv */
// ------------------------------------------------
// Synchronous packet queue with registered read data,
// prog-full flag and a reset-busy window
// ------------------------------------------------
`include "engine_pipeline_settings.svh"
`default_nettype none
`timescale 1ns/1ps

module packet_fifo #(
    parameter type payload_t = engine_pipeline_pkg::memory_payload_t
) (
    input  logic          ap_clk,
    input  logic          areset_template_engine,
    input  logic          wr_en,
    input  payload_t      din,
    input  logic          rd_en,
    output payload_t      dout,
    output logic          valid,
    fifo_status_if.source status
);

    localparam int DEPTH  = `ENGINE_FIFO_DEPTH;
    localparam int THRESH = `ENGINE_PROG_THRESH;
    localparam int BUSY   = `ENGINE_RST_BUSY_CYCLES;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int BUSY_W = $clog2(BUSY + 1) > 0 ? $clog2(BUSY + 1) : 1;

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [BUSY_W-1:0] busy_cnt;
    logic              rst_busy_q;
    logic              wr_ok;
    logic              rd_ok;

    // ------------------------------------------------
    // Status flags
    // ------------------------------------------------
    assign status.empty     = (count == '0);
    assign status.full      = (count == CNT_W'(DEPTH));
    assign status.prog_full = (count >= CNT_W'(THRESH));
    assign status.rst_busy  = rst_busy_q;

    // Nothing moves while busy
    assign wr_ok = wr_en & ~status.full & ~rst_busy_q;
    assign rd_ok = rd_en & ~status.empty & ~rst_busy_q;

    // Busy through reset, then BUSY more cycles
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            busy_cnt   <= BUSY_W'(BUSY);
            rst_busy_q <= 1'b1;
        end else begin
            if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
            rst_busy_q <= (busy_cnt > BUSY_W'(1));
        end
    end

    // ------------------------------------------------
    // Pointers and fill count
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            valid <= rd_ok;
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule : packet_fifo

`default_nettype wire

/* verilog/request_egress.sv */
// ------------------------------------------------
// Result side of a channel: queues delayed packets
// and registers them out on downstream pop
// ------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module request_egress (
    input  logic                                 ap_clk,
    input  logic                                 areset_template_engine,
    input  engine_pipeline_pkg::memory_packet_t  packet_in,
    input  logic                                 pop,
    output logic                                 out_valid,
    output engine_pipeline_pkg::memory_payload_t out_payload,
    fifo_status_if.source                        status
);

    import engine_pipeline_pkg::*;

    memory_payload_t fifo_dout;
    logic            fifo_valid;

    // Delayed packets go straight in, pop follows downstream
    packet_fifo #(
        .payload_t(memory_payload_t)
    ) fifo_inst (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .wr_en                 (packet_in.valid),
        .din                   (packet_in.payload),
        .rd_en                 (pop),
        .dout                  (fifo_dout),
        .valid                 (fifo_valid),
        .status                (status)
    );

    // ------------------------------------------------
    // Output register
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= fifo_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        out_payload <= fifo_dout;
    end

endmodule : request_egress

`default_nettype wire

/* verilog/response_ingress.sv */
// ------------------------------------------------
// Decode side of a channel: registers the incoming
// packet, queues it, pops while egress has room
// ------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module response_ingress (
    input  logic                              ap_clk,
    input  logic                              areset_template_engine,
    input  logic                              in_valid,
    input  engine_pipeline_pkg::memory_payload_t in_payload,
    fifo_status_if.sink                       egress_status,
    output engine_pipeline_pkg::memory_packet_t  packet_out,
    fifo_status_if.source                     status
);

    import engine_pipeline_pkg::*;

    logic            in_valid_q;
    memory_payload_t in_payload_q;
    memory_payload_t fifo_dout;
    logic            fifo_valid;
    logic            pop;

    // ------------------------------------------------
    // Input register
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        in_payload_q <= in_payload;
    end

    // Stall while the egress queue is past its threshold
    assign pop = ~egress_status.prog_full;

    packet_fifo #(
        .payload_t(memory_payload_t)
    ) fifo_inst (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .wr_en                 (in_valid_q),
        .din                   (in_payload_q),
        .rd_en                 (pop),
        .dout                  (fifo_dout),
        .valid                 (fifo_valid),
        .status                (status)
    );

    assign packet_out.valid   = fifo_valid;
    assign packet_out.payload = fifo_dout;

endmodule : response_ingress

`default_nettype wire

/* verilog/stage_pipeline.sv */
// ------------------------------------------------
// Execute stage: delays packets by STAGES registers,
// valid bits clear on reset
// ------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module stage_pipeline #(
    parameter int STAGES = 2
) (
    input  logic                                ap_clk,
    input  logic                                areset_template_engine,
    input  engine_pipeline_pkg::memory_packet_t packet_in,
    output engine_pipeline_pkg::memory_packet_t packet_out
);

    import engine_pipeline_pkg::*;

    logic [STAGES-1:0] valid_q;
    memory_payload_t   payload_q [STAGES];

    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= packet_in.valid;
            for (int i = 1; i < STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Payload shift, no reset
    always_ff @(posedge ap_clk) begin
        payload_q[0] <= packet_in.payload;
        for (int i = 1; i < STAGES; i++) begin
            payload_q[i] <= payload_q[i-1];
        end
    end

    assign packet_out.valid   = valid_q[STAGES-1];
    assign packet_out.payload = payload_q[STAGES-1];

endmodule : stage_pipeline

`default_nettype wire
